//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_fetch_top
BUILD_DIR   ?= build
LOG         ?= sim.log
EXTRA_FLAGS ?=

SOURCES := $(shell grep -v '^+' sim.f)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): sim.f $(SOURCES)
	$(VERILATOR) --binary --timing --assert -f sim.f --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP) $(EXTRA_FLAGS)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TEST RESULT: PASS$$' $(LOG) || (echo "pass line missing in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
src/fetch_pkg.sv
src/pc_gen.sv
src/imem_bram.sv
src/fetch_stage.sv
src/fetch_top.sv
tb/tb_clk_gen.sv
tb/tb_fetch_top.sv

//--- src/fetch_pkg.sv
`default_nettype none

// Shared widths, constants and bundles for the instruction fetch front end
package fetch_pkg;

  // Width of the program counter and of one instruction word
  localparam int xlen = 32;

  // Canonical RV32 NOP, which is addi x0, x0, 0
  localparam logic [xlen-1:0] instr_nop = 32'h0000_0013;

  // Change of fetch path requested by a later pipeline stage
  // The valid bit is a single-cycle strobe and target is the new byte address
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

  // Program load port of the instruction memory
  // The address counts words, not bytes
  typedef struct packed {
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } imem_wr_t;

  // Content of the IF/ID pipeline slot, 97 bits in total
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] instr;
  } if_id_t;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

// Fetch stage for a block RAM with one cycle of read latency
// The RAM word for an address arrives a cycle after that address, so the
// address is buffered alongside the RAM output register and both move into
// the IF/ID slot together at the following edge
module fetch_stage (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic [fetch_pkg::xlen-1:0]  pc,
  input  wire logic                        stall,
  input  wire logic                        flush,
  output logic                             imem_ren,
  output logic      [fetch_pkg::xlen-1:0]  imem_raddr,
  input  wire logic [fetch_pkg::xlen-1:0]  imem_rdata,
  output fetch_pkg::if_id_t                if_id
);

  logic [fetch_pkg::xlen-1:0] addr_buf;
  logic                       flush_ext;
  logic                       kill;
  logic                       started;
  fetch_pkg::if_id_t          slot;

  // The current PC is the fetch address
  // The read is switched off during a stall so the RAM output holds its word
  assign imem_raddr = pc;
  assign imem_ren   = !stall;

  // Address buffer
  // It loads at the same edge as the RAM output register and is frozen by
  // the same condition, so addr_buf always names the word in imem_rdata
  // It keeps tracking through a flush, since only the slot gets cleared
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_buf <= '0;
    end else if (!stall) begin
      addr_buf <= imem_raddr;
    end
  end

  // Extended flush
  // A flush in a moving cycle leaves a read of the old path in flight in the
  // RAM, and that word lands in the buffer at the next edge
  // This flag clears the slot once more at the next moving edge to drop it
  // A flush that arrives during a stall is parked here as well, because the
  // slot only changes when the chain moves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_ext <= 1'b0;
    end else if (stall) begin
      flush_ext <= flush_ext | flush;
    end else begin
      flush_ext <= flush;
    end
  end

  // Either flush source turns the next slot into a bubble
  assign kill = flush | flush_ext;

  // The RAM has delivered nothing real in the first cycle after reset
  // This flag goes high at the first moving edge and gates valid until then
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else if (!stall) begin
      started <= 1'b1;
    end
  end

  // IF/ID slot register
  // A stall holds the whole slot, a flush replaces the word by a NOP and
  // drops valid, while pc and pc_plus4 keep following the buffer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot.valid    <= 1'b0;
      slot.pc       <= '0;
      slot.pc_plus4 <= '0;
      slot.instr    <= fetch_pkg::instr_nop;
    end else if (!stall) begin
      slot.pc       <= addr_buf;
      slot.pc_plus4 <= addr_buf + 32'd4;
      if (kill) begin
        slot.valid <= 1'b0;
        slot.instr <= fetch_pkg::instr_nop;
      end else begin
        slot.valid <= started;
        slot.instr <= imem_rdata;
      end
    end
  end

  // An address presented in cycle t shows up here in cycle t+2
  assign if_id = slot;

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

// Instruction fetch front end
// PC generator, block RAM and fetch stage in one chain, ending in the
// IF/ID slot
module fetch_top #(
  parameter int          IMEM_DEPTH = 64,
  parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  stall,
  input  wire fetch_pkg::redirect_t  redirect,
  input  wire fetch_pkg::imem_wr_t   imem_wr,
  output fetch_pkg::if_id_t          if_id
);

  logic [fetch_pkg::xlen-1:0] pc;
  logic                       imem_ren;
  logic [fetch_pkg::xlen-1:0] imem_raddr;
  logic [fetch_pkg::xlen-1:0] imem_rdata;

  // Program counter with step, hold and redirect
  pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .pc       (pc)
  );

  // Instruction memory, loaded through the write port while the core waits
  imem_bram #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_imem_bram (
    .clk   (clk),
    .ren   (imem_ren),
    .raddr (imem_raddr),
    .rdata (imem_rdata),
    .wr    (imem_wr)
  );

  // Alignment buffer and slot register
  // The redirect strobe doubles as the flush of the fetch path
  fetch_stage u_fetch_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .stall      (stall),
    .flush      (redirect.valid),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .if_id      (if_id)
  );

endmodule

`default_nettype wire

//--- src/imem_bram.sv
`timescale 1ns/1ns
`default_nettype none

// Instruction memory with one cycle of read latency
// The read side is addressed in bytes and the load side in words
module imem_bram #(
  parameter int IMEM_DEPTH = 64
) (
  input  wire logic                        clk,
  input  wire logic                        ren,
  input  wire logic [fetch_pkg::xlen-1:0]  raddr,
  output logic      [fetch_pkg::xlen-1:0]  rdata,
  input  wire fetch_pkg::imem_wr_t         wr
);

  // Index width of the word array
  // IMEM_DEPTH must be a power of two of at least 2
  localparam int aw = $clog2(IMEM_DEPTH);

  logic [fetch_pkg::xlen-1:0] mem [IMEM_DEPTH];

  logic [aw-1:0] rd_idx;
  logic [aw-1:0] wr_idx;

  // Drop the two byte offset bits, then keep the low index bits
  // Addresses past the end of the array wrap around to its start
  assign rd_idx = raddr[aw+1:2];

  // The load address is already a word address
  assign wr_idx = wr.addr[aw-1:0];

  // Load port for program images
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr_idx] <= wr.data;
    end
  end

  // Registered read output
  // With ren low the output register keeps the word it last delivered
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Program counter of the fetch path
// The next value is picked from three sources, with the redirect target first
module pc_gen #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        stall,
  input  wire fetch_pkg::redirect_t        redirect,
  output logic      [fetch_pkg::xlen-1:0]  pc
);

  logic [fetch_pkg::xlen-1:0] pc_seq;
  logic [fetch_pkg::xlen-1:0] pc_next;

  // Sequential successor, one 32-bit instruction further
  assign pc_seq = pc + 32'd4;

  // A redirect wins over a stall, so a target given while the pipe is frozen
  // is already in the PC when the chain starts moving again
  always_comb begin
    if (redirect.valid) begin
      pc_next = redirect.target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc_seq;
    end
  end

  // The PC is the fetch address of the current cycle
  // A strobe in cycle t shows up here in cycle t+1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- tb/fetch_stim.txt
# L <word address hex> <data hex> loads a word; R <n> runs n cycles; S <n> stalls n cycles
# S 0 stalls 1 to 4 random cycles; J <target hex> <s> redirects, with stall held when s is 1
L 00000000 00100093
L 00000001 00200113
L 00000002 002081b3
L 00000003 40110233
L 00000004 0020f2b3
L 00000005 0041e333
L 00000048 00c0006f
L 00000010 fe5ff06f
L 00000011 00532023
L 00000020 00008067
L 00000021 00a00513
L 00000022 00b505b3
L 0000003c 0000100f
L 0000003d 00000073
L 0000003e 00100073
L 0000003f 30200073
R 10
S 3
R 5
J 00000080 0
R 8
S 0
R 3
S 0
R 4
J 000000f0 0
R 10
S 2
J 00000040 1
S 2
R 6
J 00000020 0
J 00000010 0
R 8
S 0
J 00000004 1
R 6
S 0
R 3

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock and a synchronous active-low reset
module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset covers RESET_CYCLES rising edges and is released on a falling edge,
  // away from any edge that the DUT samples
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

// Testbench for the fetch front end driven by a command script
module tb_fetch_top;

  localparam int          IMEM_DEPTH = 64;
  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam logic [31:0] SEED       = 32'h0b8df174;
  localparam string       STIM_FILE  = "tb/fetch_stim.txt";

  logic                 clk;
  logic                 rst_n;
  logic                 stall;
  fetch_pkg::redirect_t redirect;
  fetch_pkg::imem_wr_t  imem_wr;
  fetch_pkg::if_id_t    if_id;

  // Expected memory image and the parsed script
  logic [31:0] model_mem [IMEM_DEPTH];
  byte         cmd_q [$];
  logic [31:0] arg_a_q [$];
  logic [31:0] arg_b_q [$];

  int   cycle_limit;
  int   cycle_count = 0;
  logic playing = 1'b0;

  // The reference model state is updated on every rising edge
  logic [31:0]       exp_pc;
  fetch_pkg::if_id_t prev_slot;
  logic              prev_stall;
  logic              prev_rst_n;
  logic              have_prev = 1'b0;
  int                moves = 0;
  logic              redir_pending = 1'b0;
  int                redir_moves = 0;
  int                slots_checked = 0;

  tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  fetch_top #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .RESET_PC   (RESET_PC)
  ) u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .imem_wr  (imem_wr),
    .if_id    (if_id)
  );

  // Folds a word address into the memory, which wraps at IMEM_DEPTH words
  function automatic int wrap_word(input logic [31:0] word_addr);
    return int'(word_addr % 32'(IMEM_DEPTH));
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_slot_mismatch(input string test, input fetch_pkg::if_id_t expected,
                                      input fetch_pkg::if_id_t actual);
    $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", test, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Reads the script, builds the model memory and the cycle budget
  task automatic read_script();
    int          fd;
    int          n;
    int          need;
    string       line;
    string       rest;
    byte         c;
    logic [31:0] a;
    logic [31:0] b;
    // Fill pattern covers words the script never loads
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      model_mem[i] = 32'hc000_0013 ^ (32'(i) * 32'h0001_0004);
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the stimulus file tb/fetch_stim.txt");
    end
    cycle_limit = 20;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2) begin
        continue;
      end
      c = line.getc(0);
      rest = line.substr(1, line.len() - 1);
      a = '0;
      b = '0;
      n = 0;
      need = 0;
      if (c == "#") begin
        continue;
      end else if (c == "L" || c == "J") begin
        n = $sscanf(rest, "%h %h", a, b);
        need = 2;
      end else if (c == "R" || c == "S") begin
        n = $sscanf(rest, "%d", a);
        need = 1;
      end else begin
        stop_with_failure("The stimulus file holds an unknown command");
      end
      if (n != need) begin
        stop_with_failure("A stimulus line has fewer fields than its command needs");
      end
      if (c == "L") begin
        model_mem[wrap_word(a)] = b;
      end else if (c == "J") begin
        cycle_limit += 4;
      end else begin
        // A zero stall length is random and at most 4 cycles long
        cycle_limit += (c == "S" && a == 0) ? 4 : int'(a);
      end
      if (c != "L") begin
        cmd_q.push_back(c);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  // Writes the whole model image while the core is held in reset or by stall
  task automatic load_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(negedge clk);
      imem_wr.we   = 1'b1;
      imem_wr.addr = 32'(i);
      imem_wr.data = model_mem[i];
    end
    @(negedge clk);
    imem_wr = '0;
  endtask

  // Sets the inputs for one cycle on the falling edge
  task automatic drive_cycle(input logic stall_val, input fetch_pkg::redirect_t redir_val);
    @(negedge clk);
    stall    = stall_val;
    redirect = redir_val;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0);
  endtask

  task automatic stall_cycles(input int n);
    repeat (n) drive_cycle(1'b1, '0);
  endtask

  // Checks one new valid slot against the model and steps the model
  task automatic check_slot();
    assert (if_id.pc == exp_pc) else report_mismatch("slot_pc", exp_pc, if_id.pc);
    assert (if_id.pc_plus4 == exp_pc + 32'd4)
      else report_mismatch("slot_pc_plus4", exp_pc + 32'd4, if_id.pc_plus4);
    assert (if_id.instr == model_mem[wrap_word(exp_pc >> 2)])
      else report_mismatch("slot_instr", model_mem[wrap_word(exp_pc >> 2)], if_id.instr);
    redir_pending = 1'b0;
    exp_pc = exp_pc + 32'd4;
    slots_checked++;
  endtask

  // The checker sees the slot as it stood before this edge
  // It also sees the inputs that the DUT samples at this same edge
  always @(posedge clk) begin
    if (have_prev) begin
      if (!prev_rst_n) begin
        assert (!if_id.valid) else report_mismatch("reset_valid", 32'd0, {31'd0, if_id.valid});
      end else if (prev_stall) begin
        assert (if_id == prev_slot) else report_slot_mismatch("stall_hold", prev_slot, if_id);
      end else if (moves < 2) begin
        assert (!if_id.valid)
          else report_mismatch("first_cycle_valid", 32'd0, {31'd0, if_id.valid});
      end else if (redir_pending && !if_id.valid) begin
        // The flush keeps the slot empty for at most two moving edges
        assert (redir_moves < 3)
          else stop_with_failure("The redirect target did not reach the IF/ID slot in time");
      end else begin
        // Outside a flush every moving edge delivers the next instruction
        assert (if_id.valid) else report_mismatch("slot_valid", 32'd1, {31'd0, if_id.valid});
        check_slot();
      end
    end
    if (!rst_n) begin
      exp_pc        = RESET_PC;
      moves         = 0;
      redir_pending = 1'b0;
    end else begin
      if (redirect.valid) begin
        exp_pc        = redirect.target;
        redir_pending = 1'b1;
        redir_moves   = stall ? 0 : 1;
      end else if (redir_pending && !stall) begin
        redir_moves++;
      end
      if (!stall) begin
        moves++;
      end
    end
    prev_slot  = if_id;
    prev_stall = stall;
    prev_rst_n = rst_n;
    have_prev  = 1'b1;
  end

  // The cycle budget counts from the first script command
  always @(posedge clk) begin
    if (playing) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
        stop_with_failure($sformatf("Timeout, the script did not end within %0d cycles",
                                    cycle_limit));
      end
    end
  end

  initial begin
    stall    = 1'b1;
    redirect = '0;
    imem_wr  = '0;
    void'($urandom(SEED));
    read_script();
    load_program();
    wait (rst_n == 1'b1);
    playing = 1'b1;
    foreach (cmd_q[k]) begin
      if (cmd_q[k] == "R") begin
        run_cycles(int'(arg_a_q[k]));
      end else if (cmd_q[k] == "S") begin
        stall_cycles(arg_a_q[k] == 0 ? int'(1 + ($urandom % 4)) : int'(arg_a_q[k]));
      end else begin
        drive_cycle(arg_b_q[k][0], {1'b1, arg_a_q[k]});
      end
    end
    // Let the words still in flight reach the slot
    run_cycles(4);
    if (slots_checked == 0) begin
      $display("No valid instruction reached the IF/ID slot");
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
